//--- mem_stage_top.f
hdl/mem_stage_pkg.sv
hdl/exe_mem_reg.sv
hdl/dmem_wb_master.sv
hdl/mem_wb_reg.sv
hdl/mem_stage_top.sv
tests/wb_mem_model.sv
tests/tb_mem_stage.sv

//--- Makefile
# Verilator build and run for the memory stage testbench

TOP       ?= tb_mem_stage
SEED      ?= 1
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD     ?= obj_dir

FILELIST  := mem_stage_top.f
SOURCES   := $(wildcard hdl/*.sv tests/*.sv)
BIN       := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --assert -j 0 --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	$(BIN) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tests/tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int IN_DELAY   = 2;
    localparam int MAX_CYCLES = 2000; // tests need roughly 450 cycles

    logic       clk;
    logic       rst;
    logic       ex_valid;
    word_t      ex_alu_out;
    word_t      ex_rs2;
    word_t      ex_u_imm;
    logic       ex_br_en;
    fwd_sel_e   ex_fwd_sel;
    mem_op_e    ex_mem_op;
    funct3_t    ex_funct3;
    reg_idx_t   ex_rd;
    logic       ex_ready;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    sel_t       wb_sel;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       wb_valid;
    logic       rf_we;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    order_t     wb_order;
    logic [3:0] ack_wait;

    int     seed       = 32'h1501_d33e;
    int     cycle_cnt  = 0;
    int     checks     = 0;
    int     value_errs = 0;
    int     proto_errs = 0;
    order_t next_order = '0;
    word_t  ref_mem [256];

    // expected retirements and bus beats in issue order
    word_t    exp_data_q[$];
    logic     exp_we_q[$];
    reg_idx_t exp_rd_q[$];
    int       exp_cycle_q[$];
    word_t    bus_adr_q[$];
    sel_t     bus_sel_q[$];
    logic     bus_we_q[$];
    word_t    bus_dat_q[$];

    logic  bus_held    = 1'b0;
    logic  mem_pending = 1'b0; // load or store accepted and not yet acked
    logic  ack_seen    = 1'b0;
    int    ack_cycle   = 0;
    word_t prev_adr;
    word_t prev_dat;
    sel_t  prev_sel;
    logic  prev_we;

    mem_stage_top DUT (
        .clk          (clk),
        .rst          (rst),
        .ex_valid_i   (ex_valid),
        .ex_alu_out_i (ex_alu_out),
        .ex_rs2_i     (ex_rs2),
        .ex_u_imm_i   (ex_u_imm),
        .ex_br_en_i   (ex_br_en),
        .ex_fwd_sel_i (ex_fwd_sel),
        .ex_mem_op_i  (ex_mem_op),
        .ex_funct3_i  (ex_funct3),
        .ex_rd_i      (ex_rd),
        .ex_ready_o   (ex_ready),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .wb_adr_o     (wb_adr),
        .wb_sel_o     (wb_sel),
        .wb_dat_o     (wb_dat_w),
        .wb_dat_i     (wb_dat_r),
        .wb_ack_i     (wb_ack),
        .wb_valid_o   (wb_valid),
        .wb_rf_we_o   (rf_we),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data),
        .wb_order_o   (wb_order)
    );

    wb_mem_model u_mem (
        .clk        (clk),
        .rst        (rst),
        .ack_wait_i (ack_wait),
        .cyc_i      (wb_cyc),
        .stb_i      (wb_stb),
        .we_i       (wb_we),
        .adr_i      (wb_adr),
        .sel_i      (wb_sel),
        .dat_i      (wb_dat_w),
        .ack_o      (wb_ack),
        .dat_o      (wb_dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rule(input string what, input logic ok);
        checks++;
        assert (ok) else begin
            proto_errs++;
            $display("at %0t ns: %s", $time, what);
        end
    endtask

    function automatic int size_bytes(input funct3_t f3);
        case (f3)
            F3_B, F3_BU: return 1;
            F3_H, F3_HU: return 2;
            default:     return 4; // unknown size is a word
        endcase
    endfunction

    // drives one instruction at posedge+IN_DELAY and returns after it is accepted
    task automatic send(input mem_op_e op, input fwd_sel_e fsel, input funct3_t f3,
                        input word_t alu, input word_t rs2, input word_t uimm,
                        input logic br, input reg_idx_t rd);
        int    n;
        int    off;
        int    idx;
        word_t exp_data;
        word_t wdata;
        word_t stored;
        sel_t  sel;
        logic  ready;
        n        = size_bytes(f3);
        off      = int'(alu[1:0]);
        idx      = int'(alu[9:2]);
        sel      = '0;
        wdata    = '0;
        exp_data = '0;
        stored   = ref_mem[idx];
        for (int b = 0; b < 4; b++) begin
            if (b >= off) begin
                wdata[8*b +: 8] = rs2[8*(b-off) +: 8];
            end
            if (b >= off && b < off + n) begin
                sel[b]           = 1'b1;
                stored[8*b +: 8] = rs2[8*(b-off) +: 8];
            end
        end
        if (op == MEM_LOAD) begin
            for (int b = 0; b < n; b++) begin
                if (off + b < 4) begin
                    exp_data[8*b +: 8] = ref_mem[idx][8*(off+b) +: 8];
                end
            end
            if ((f3 == F3_B || f3 == F3_H) && exp_data[8*n-1]) begin
                for (int b = n; b < 4; b++) begin
                    exp_data[8*b +: 8] = 8'hFF;
                end
            end
        end else if (fsel == FWD_BR_EN) begin
            exp_data = {31'b0, br};
        end else if (fsel == FWD_U_IMM) begin
            exp_data = uimm;
        end else begin
            exp_data = alu;
        end
        ex_valid   = 1'b1;
        ex_mem_op  = op;
        ex_fwd_sel = fsel;
        ex_funct3  = f3;
        ex_alu_out = alu;
        ex_rs2     = rs2;
        ex_u_imm   = uimm;
        ex_br_en   = br;
        ex_rd      = rd;
        ready      = 1'b0;
        while (!ready) begin
            @(negedge clk);
            ready = ex_ready;
            @(posedge clk);
            #IN_DELAY;
        end
        ex_valid = 1'b0;
        exp_data_q.push_back(exp_data);
        exp_we_q.push_back(op != MEM_STORE && rd != 5'd0);
        exp_rd_q.push_back(rd);
        exp_cycle_q.push_back(op == MEM_NONE ? cycle_cnt + 1 : -1);
        if (op != MEM_NONE) begin
            mem_pending = 1'b1;
            bus_adr_q.push_back({alu[31:2], 2'b00});
            bus_sel_q.push_back(sel);
            bus_we_q.push_back(op == MEM_STORE);
            bus_dat_q.push_back(wdata);
        end
        if (op == MEM_STORE) begin
            ref_mem[idx] = stored;
        end
    endtask

    task automatic mem_access(input mem_op_e op, input funct3_t f3, input logic [7:0] idx,
                              input logic [1:0] off, input word_t data);
        word_t hi;
        hi = $random(seed); // upper address bits only test the alignment
        send(op, FWD_ALU, f3, {hi[31:10], idx, off}, data, 32'h0, 1'b0, 5'(idx | 8'h01));
    endtask

    task automatic drain();
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #IN_DELAY;
    endtask

    task automatic match_bus_beat();
        logic  we;
        word_t dat;
        if (bus_adr_q.size() == 0) begin
            check_rule("a bus cycle ran without a load or store", 1'b0);
        end else begin
            we  = bus_we_q.pop_front();
            dat = bus_dat_q.pop_front();
            check_value("wb_adr_o", wb_adr, bus_adr_q.pop_front());
            check_value("wb_sel_o", 32'(wb_sel), 32'(bus_sel_q.pop_front()));
            check_value("wb_we_o", 32'(wb_we), 32'(we));
            if (we) begin
                check_value("wb_dat_o", wb_dat_w, dat);
            end
        end
    endtask

    task automatic match_retirement();
        int exp_cyc;
        if (exp_data_q.size() == 0) begin
            check_rule("an instruction retired that was never sent", 1'b0);
        end else begin
            exp_cyc = exp_cycle_q.pop_front();
            if (exp_cyc >= 0) begin
                check_value("retire cycle", cycle_cnt, exp_cyc);
            end else begin
                check_value("retire cycle after ack", cycle_cnt, ack_cycle + 1);
            end
            check_value("wb_data_o", wb_data, exp_data_q.pop_front());
            check_value("wb_rf_we_o", 32'(rf_we), 32'(exp_we_q.pop_front()));
            check_value("wb_rd_o", 32'(wb_rd), 32'(exp_rd_q.pop_front()));
            checks++;
            assert (wb_order === next_order) else begin
                value_errs++;
                $display("error at %0t ns: wb_order_o is %0d, expected %0d",
                         $time, wb_order, next_order);
            end
            next_order++;
        end
    endtask

    // monitor samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            check_rule("wb_cyc_o and wb_stb_o differ", wb_cyc == wb_stb);
            if (bus_held) begin
                check_rule("bus outputs changed before ack", wb_stb && wb_adr == prev_adr
                           && wb_sel == prev_sel && wb_we == prev_we && wb_dat_w == prev_dat);
            end
            if (ack_seen) begin
                check_rule("wb_stb_o stayed high in the cycle after ack", !wb_stb);
            end
            if (mem_pending && !wb_ack) begin
                check_rule("ex_ready_o was high while a load or store was pending", !ex_ready);
            end
            if (wb_stb && wb_ack) begin
                match_bus_beat();
                mem_pending = 1'b0;
                ack_cycle   = cycle_cnt;
            end
            if (wb_valid) begin
                match_retirement();
            end
            bus_held = wb_stb && !wb_ack;
            ack_seen = wb_stb && wb_ack;
            prev_adr = wb_adr;
            prev_sel = wb_sel;
            prev_we  = wb_we;
            prev_dat = wb_dat_w;
        end else begin
            bus_held    = 1'b0;
            ack_seen    = 1'b0;
            mem_pending = 1'b0;
        end
    end

    task automatic compare_memory();
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("memory word %0d", i), u_mem.mem[i], ref_mem[i]);
        end
    endtask

    task automatic run_forwarding();
        word_t    a;
        word_t    u;
        fwd_sel_e fsel;
        for (int i = 0; i < 6; i++) begin
            a    = $random(seed);
            u    = $random(seed);
            fsel = (i % 3 == 0) ? FWD_ALU : (i % 3 == 1) ? FWD_BR_EN : FWD_U_IMM;
            send(MEM_NONE, fsel, F3_W, a, 32'h0, u, a[0], 5'(i * 5)); // rd 0 first
        end
        drain();
    endtask

    task automatic store_lanes();
        ack_wait = 4'd1;
        for (int o = 0; o < 4; o++) begin
            mem_access(MEM_STORE, F3_B, 8'(16 + o), 2'(o), $random(seed));
            mem_access(MEM_STORE, F3_B, 8'd30, 2'(o), $random(seed));
        end
        mem_access(MEM_STORE, F3_H, 8'd20, 2'd0, $random(seed));
        mem_access(MEM_STORE, F3_H, 8'd21, 2'd2, $random(seed));
        mem_access(MEM_STORE, F3_W, 8'd24, 2'd0, $random(seed));
        drain();
        compare_memory();
    endtask

    task automatic load_extension();
        ack_wait = 4'd2;
        mem_access(MEM_STORE, F3_W, 8'd40, 2'd0, 32'h8C7F_01FE);
        mem_access(MEM_STORE, F3_W, 8'd41, 2'd0, 32'h7F80_FF01);
        for (int w = 40; w < 42; w++) begin
            for (int o = 0; o < 4; o++) begin
                mem_access(MEM_LOAD, F3_B, 8'(w), 2'(o), '0);
                mem_access(MEM_LOAD, F3_BU, 8'(w), 2'(o), '0);
            end
            for (int o = 0; o < 4; o += 2) begin
                mem_access(MEM_LOAD, F3_H, 8'(w), 2'(o), '0);
                mem_access(MEM_LOAD, F3_HU, 8'(w), 2'(o), '0);
            end
            mem_access(MEM_LOAD, F3_W, 8'(w), 2'd0, '0);
        end
        mem_access(MEM_LOAD, F3_W, 8'd30, 2'd0, '0); // word built from byte stores
        drain();
    endtask

    task automatic back_pressure();
        for (int w = 0; w < 4; w++) begin
            ack_wait = 4'(w);
            mem_access(MEM_STORE, F3_W, 8'(50 + w), 2'd0, $random(seed));
            mem_access(MEM_LOAD, F3_W, 8'(50 + w), 2'd0, '0);
            send(MEM_NONE, FWD_U_IMM, F3_W, 32'h0, 32'h0, $random(seed), 1'b0, 5'd7);
            mem_access(MEM_STORE, F3_H, 8'(50 + w), 2'd2, $random(seed));
            mem_access(MEM_LOAD, F3_H, 8'(50 + w), 2'd2, '0);
            send(MEM_NONE, FWD_BR_EN, F3_W, 32'h0, 32'h0, 32'h0, 1'b1, 5'd9);
            drain();
        end
    endtask

    task automatic reset_and_order();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_rule("wb_valid_o high during reset", !wb_valid);
        check_rule("wb_cyc_o high during reset", !wb_cyc && !wb_stb && !wb_we);
        check_rule("wb_rf_we_o high during reset", !rf_we);
        check_value("wb_order_o low word", wb_order[31:0], '0);
        check_value("wb_order_o high word", wb_order[63:32], '0);
        @(posedge clk);
        #IN_DELAY;
        rst        = 1'b0;
        next_order = '0;
        @(negedge clk);
        check_rule("ex_ready_o high before the first edge after reset", !ex_ready);
        @(posedge clk);
        #IN_DELAY;
        send(MEM_NONE, FWD_ALU, F3_W, $random(seed), 32'h0, 32'h0, 1'b0, 5'd3);
        mem_access(MEM_LOAD, F3_HU, 8'd41, 2'd2, '0);
        drain();
    endtask

    initial begin
        rst        = 1'b1;
        ex_valid   = 1'b0;
        ex_alu_out = '0;
        ex_rs2     = '0;
        ex_u_imm   = '0;
        ex_br_en   = 1'b0;
        ex_fwd_sel = FWD_ALU;
        ex_mem_op  = MEM_NONE;
        ex_funct3  = F3_W;
        ex_rd      = '0;
        ack_wait   = 4'd0;
        repeat (8) @(posedge clk);
        #IN_DELAY;
        rst = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = u_mem.mem[i]; // starting contents of the slave
        end
        run_forwarding();
        store_lanes();
        load_extension();
        back_pressure();
        reset_and_order();
        check_rule("retirements still expected at the end", exp_data_q.size() == 0);
        check_rule("bus cycles still expected at the end", bus_adr_q.size() == 0);
        $display("checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_mem_stage

//--- tests/wb_mem_model.sv
`timescale 1ns/1ns

module wb_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [3:0]           ack_wait_i, // cycles of stb before ack is raised
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  mem_stage_pkg::word_t adr_i,
    input  mem_stage_pkg::sel_t  sel_i,
    input  mem_stage_pkg::word_t dat_i,
    output logic                 ack_o,
    output mem_stage_pkg::word_t dat_o
);
    import mem_stage_pkg::*;

    word_t      mem [256];
    logic [3:0] wait_cnt;
    logic [7:0] idx;
    logic       hit;

    assign idx = adr_i[9:2];
    assign hit = cyc_i && stb_i && !ack_o && (wait_cnt == ack_wait_i);

    // fill pattern uses every address bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'hA5, 8'(i), ~8'(i), 8'(i) + 8'h3C};
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o    <= 1'b0;
            wait_cnt <= 4'd0;
        end else if (ack_o) begin
            ack_o    <= 1'b0; // one ack per access
            wait_cnt <= 4'd0;
        end else if (cyc_i && stb_i) begin
            if (wait_cnt == ack_wait_i) begin
                ack_o <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 4'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (hit) begin
            dat_o <= mem[idx];
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (we_i && sel_i[b]) begin
                    mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

endmodule : wb_mem_model

//--- hdl/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ex_valid_i,
    input  mem_stage_pkg::word_t     ex_alu_out_i,
    input  mem_stage_pkg::word_t     ex_rs2_i,
    input  mem_stage_pkg::word_t     ex_u_imm_i,
    input  logic                     ex_br_en_i,
    input  mem_stage_pkg::fwd_sel_e  ex_fwd_sel_i,
    input  mem_stage_pkg::mem_op_e   ex_mem_op_i,
    input  mem_stage_pkg::funct3_t   ex_funct3_i,
    input  mem_stage_pkg::reg_idx_t  ex_rd_i,
    output logic                     ex_ready_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output mem_stage_pkg::word_t     wb_adr_o,
    output mem_stage_pkg::sel_t      wb_sel_o,
    output mem_stage_pkg::word_t     wb_dat_o,
    input  mem_stage_pkg::word_t     wb_dat_i,
    input  logic                     wb_ack_i,
    output logic                     wb_valid_o,
    output logic                     wb_rf_we_o, // register file write enable
    output mem_stage_pkg::reg_idx_t  wb_rd_o,
    output mem_stage_pkg::word_t     wb_data_o,
    output mem_stage_pkg::order_t    wb_order_o
);
    import mem_stage_pkg::*;

    logic                 mem_valid;
    logic                 mem_done;
    word_t                mem_fwd_data;
    word_t                mem_addr;
    sel_t                 mem_sel;
    word_t                mem_wdata;
    word_t                mem_rdata;
    mem_op_e              mem_op;
    funct3_t              mem_funct3;
    logic [LANE_BITS-1:0] mem_offset;
    reg_idx_t             mem_rd;

    exe_mem_reg u_exe_mem (
        .clk            (clk),
        .rst            (rst),
        .ex_valid_i     (ex_valid_i),
        .ex_alu_out_i   (ex_alu_out_i),
        .ex_rs2_i       (ex_rs2_i),
        .ex_u_imm_i     (ex_u_imm_i),
        .ex_br_en_i     (ex_br_en_i),
        .ex_fwd_sel_i   (ex_fwd_sel_i),
        .ex_mem_op_i    (ex_mem_op_i),
        .ex_funct3_i    (ex_funct3_i),
        .ex_rd_i        (ex_rd_i),
        .mem_done_i     (mem_done),
        .ex_ready_o     (ex_ready_o),
        .mem_valid_o    (mem_valid),
        .mem_fwd_data_o (mem_fwd_data),
        .mem_addr_o     (mem_addr),
        .mem_sel_o      (mem_sel),
        .mem_wdata_o    (mem_wdata),
        .mem_op_o       (mem_op),
        .mem_funct3_o   (mem_funct3),
        .mem_offset_o   (mem_offset),
        .mem_rd_o       (mem_rd)
    );

    dmem_wb_master u_dmem (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid),
        .mem_op_i    (mem_op),
        .mem_addr_i  (mem_addr),
        .mem_sel_i   (mem_sel),
        .mem_wdata_i (mem_wdata),
        .wb_ack_i    (wb_ack_i),
        .wb_dat_i    (wb_dat_i),
        .mem_done_o  (mem_done),
        .mem_rdata_o (mem_rdata),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_o    (wb_dat_o)
    );

    mem_wb_reg u_mem_wb (
        .clk            (clk),
        .rst            (rst),
        .mem_done_i     (mem_done),
        .mem_fwd_data_i (mem_fwd_data),
        .mem_rdata_i    (mem_rdata),
        .mem_op_i       (mem_op),
        .mem_funct3_i   (mem_funct3),
        .mem_offset_i   (mem_offset),
        .mem_rd_i       (mem_rd),
        .wb_valid_o     (wb_valid_o),
        .wb_we_o        (wb_rf_we_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .wb_order_o     (wb_order_o)
    );

endmodule : mem_stage_top

//--- hdl/mem_wb_reg.sv
`timescale 1ns/1ns

module mem_wb_reg (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                mem_done_i,
    input  mem_stage_pkg::word_t                mem_fwd_data_i,
    input  mem_stage_pkg::word_t                mem_rdata_i,
    input  mem_stage_pkg::mem_op_e              mem_op_i,
    input  mem_stage_pkg::funct3_t              mem_funct3_i,
    input  logic [mem_stage_pkg::LANE_BITS-1:0] mem_offset_i,
    input  mem_stage_pkg::reg_idx_t             mem_rd_i,
    output logic                                wb_valid_o,
    output logic                                wb_we_o,
    output mem_stage_pkg::reg_idx_t             wb_rd_o,
    output mem_stage_pkg::word_t                wb_data_o,
    output mem_stage_pkg::order_t               wb_order_o
);
    import mem_stage_pkg::*;

    word_t  shifted;
    word_t  load_val;
    word_t  result;
    order_t order_q; // number for the next retiring item

    assign shifted = mem_rdata_i >> {mem_offset_i, 3'b000}; // lane down to bit 0

    always_comb begin
        case (mem_funct3_i)
            F3_B:    load_val = {{24{shifted[7]}}, shifted[7:0]};
            F3_BU:   load_val = {24'b0, shifted[7:0]};
            F3_H:    load_val = {{16{shifted[15]}}, shifted[15:0]};
            F3_HU:   load_val = {16'b0, shifted[15:0]};
            default: load_val = shifted;
        endcase
    end

    assign result = (mem_op_i == MEM_LOAD) ? load_val : mem_fwd_data_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_order_o <= '0;
            order_q    <= '0;
        end else begin
            wb_valid_o <= mem_done_i;
            wb_we_o    <= mem_done_i && (mem_op_i != MEM_STORE) && (mem_rd_i != '0);
            if (mem_done_i) begin
                wb_order_o <= order_q;
                order_q    <= order_q + 64'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_done_i) begin
            wb_rd_o   <= mem_rd_i;
            wb_data_o <= result;
        end
    end

endmodule : mem_wb_reg

//--- hdl/dmem_wb_master.sv
`timescale 1ns/1ns

module dmem_wb_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_valid_i,
    input  mem_stage_pkg::mem_op_e mem_op_i,
    input  mem_stage_pkg::word_t   mem_addr_i,
    input  mem_stage_pkg::sel_t    mem_sel_i,
    input  mem_stage_pkg::word_t   mem_wdata_i,
    input  logic                   wb_ack_i,
    input  mem_stage_pkg::word_t   wb_dat_i,
    output logic                   mem_done_o,
    output mem_stage_pkg::word_t   mem_rdata_o,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output mem_stage_pkg::word_t   wb_adr_o,
    output mem_stage_pkg::sel_t    wb_sel_o,
    output mem_stage_pkg::word_t   wb_dat_o
);
    import mem_stage_pkg::*;

    bus_state_e state_q;
    logic       launch;
    logic       ack;

    // idle state is always visited once, so back-to-back items get a gap
    assign launch = (state_q == BUS_IDLE) && mem_valid_i && (mem_op_i != MEM_NONE);
    assign ack    = (state_q == BUS_WAIT) && wb_ack_i;

    assign wb_cyc_o    = (state_q == BUS_WAIT);
    assign wb_stb_o    = (state_q == BUS_WAIT);
    assign mem_done_o  = (mem_valid_i && (mem_op_i == MEM_NONE)) || ack;
    assign mem_rdata_o = wb_dat_i; // sampled downstream on the ack cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= BUS_IDLE;
            wb_we_o <= 1'b0;
        end else begin
            case (state_q)
                BUS_IDLE: begin
                    if (launch) begin
                        state_q <= BUS_WAIT;
                        wb_we_o <= (mem_op_i == MEM_STORE);
                    end
                end
                BUS_WAIT: begin
                    if (wb_ack_i) begin
                        state_q <= BUS_IDLE;
                        wb_we_o <= 1'b0;
                    end
                end
                default: state_q <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            wb_adr_o <= mem_addr_i;
            wb_sel_o <= mem_sel_i;
            wb_dat_o <= mem_wdata_i;
        end
    end

    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        (state_q == BUS_WAIT) && !wb_ack_i |=> (state_q == BUS_WAIT)
            && $stable(wb_adr_o) && $stable(wb_sel_o)
            && $stable(wb_we_o) && $stable(wb_dat_o));

endmodule : dmem_wb_master

//--- hdl/exe_mem_reg.sv
`timescale 1ns/1ns

module exe_mem_reg (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ex_valid_i,
    input  mem_stage_pkg::word_t                ex_alu_out_i,
    input  mem_stage_pkg::word_t                ex_rs2_i,
    input  mem_stage_pkg::word_t                ex_u_imm_i,
    input  logic                                ex_br_en_i,
    input  mem_stage_pkg::fwd_sel_e             ex_fwd_sel_i,
    input  mem_stage_pkg::mem_op_e              ex_mem_op_i,
    input  mem_stage_pkg::funct3_t              ex_funct3_i,
    input  mem_stage_pkg::reg_idx_t             ex_rd_i,
    input  logic                                mem_done_i,
    output logic                                ex_ready_o,
    output logic                                mem_valid_o,
    output mem_stage_pkg::word_t                mem_fwd_data_o,
    output mem_stage_pkg::word_t                mem_addr_o,
    output mem_stage_pkg::sel_t                 mem_sel_o,
    output mem_stage_pkg::word_t                mem_wdata_o,
    output mem_stage_pkg::mem_op_e              mem_op_o,
    output mem_stage_pkg::funct3_t              mem_funct3_o,
    output logic [mem_stage_pkg::LANE_BITS-1:0] mem_offset_o,
    output mem_stage_pkg::reg_idx_t             mem_rd_o
);
    import mem_stage_pkg::*;

    logic                 started_q; // no accept before first edge out of reset
    logic                 take;
    logic                 is_mem;
    logic [LANE_BITS-1:0] offset;
    sel_t                 lanes;
    word_t                fwd_d;
    word_t                addr_d;
    sel_t                 sel_d;
    word_t                wdata_d;

    assign offset     = ex_alu_out_i[LANE_BITS-1:0];
    assign is_mem     = (ex_mem_op_i != MEM_NONE);
    assign ex_ready_o = started_q && (!mem_valid_o || mem_done_i);
    assign take       = ex_valid_i && ex_ready_o;

    always_comb begin
        case (ex_fwd_sel_i)
            FWD_ALU:   fwd_d = ex_alu_out_i;
            FWD_BR_EN: fwd_d = {31'b0, ex_br_en_i};
            FWD_U_IMM: fwd_d = ex_u_imm_i;
            default:   fwd_d = ex_alu_out_i;
        endcase
    end

    always_comb begin
        case (ex_funct3_i)
            F3_B, F3_BU: lanes = 4'b0001;
            F3_H, F3_HU: lanes = 4'b0011;
            F3_W:        lanes = 4'b1111;
            default:     lanes = 4'b1111; // unknown size acts as word
        endcase
    end

    always_comb begin
        addr_d  = ex_alu_out_i;
        sel_d   = '0;
        wdata_d = ex_rs2_i;
        if (is_mem) begin
            addr_d  = {ex_alu_out_i[31:LANE_BITS], {LANE_BITS{1'b0}}};
            sel_d   = lanes << offset;
            wdata_d = ex_rs2_i << {offset, 3'b000}; // byte lane alignment
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started_q   <= 1'b0;
            mem_valid_o <= 1'b0;
            mem_op_o    <= MEM_NONE;
        end else begin
            started_q <= 1'b1;
            if (take) begin
                mem_valid_o <= 1'b1;
                mem_op_o    <= ex_mem_op_i;
            end else if (mem_done_i) begin
                mem_valid_o <= 1'b0;
                mem_op_o    <= MEM_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem_fwd_data_o <= fwd_d;
            mem_addr_o     <= addr_d;
            mem_sel_o      <= sel_d;
            mem_wdata_o    <= wdata_d;
            mem_funct3_o   <= ex_funct3_i;
            mem_offset_o   <= offset;
            mem_rd_o       <= ex_rd_i;
        end
    end

    a_sel_nonzero: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && (mem_op_o != MEM_NONE) |-> mem_sel_o != '0);

    // a held item blocks execute and is still there next cycle
    a_hold: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_done_i |-> !ex_ready_o ##1 (mem_valid_o && $stable(mem_addr_o)));

endmodule : exe_mem_reg

//--- hdl/mem_stage_pkg.sv
package mem_stage_pkg;

    localparam int BYTES_PER_WORD = 4;
    localparam int LANE_BITS      = 2; // address bits that pick a byte lane

    typedef logic [8*BYTES_PER_WORD-1:0] word_t;
    typedef logic [BYTES_PER_WORD-1:0]   sel_t;
    typedef logic [4:0]                  reg_idx_t;
    typedef logic [63:0]                 order_t;
    typedef logic [2:0]                  funct3_t;

    // RV32I load/store size encodings
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        FWD_ALU,
        FWD_BR_EN,
        FWD_U_IMM
    } fwd_sel_e;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_e;

endpackage : mem_stage_pkg
